// File: verilog/nes_loader_macros.svh
// ================================================
// Host register map, iNES signature bytes and
// loader address constants
// ================================================
`ifndef NES_LOADER_MACROS_SVH
`define NES_LOADER_MACROS_SVH

// Host register addresses
`define NES_REG_CONF  8'h35  // Bit 0 holds the loader in reset
`define NES_REG_ROM   8'h37  // ROM byte stream
`define NES_REG_BTN1  8'h40
`define NES_REG_BTN2  8'h41

// Linear memory layout
`define NES_CHR_BASE  22'h200000
`define NES_PRG_SHIFT 14     // 16 KiB PRG units
`define NES_CHR_SHIFT 13     // 8 KiB CHR units

// "NES" followed by MS-DOS EOF
`define NES_MAGIC_0   8'h4E
`define NES_MAGIC_1   8'h45
`define NES_MAGIC_2   8'h53
`define NES_MAGIC_3   8'h1A

`endif

// File: verilog/nes_cart_pkg.sv
// ================================================
// Cartridge types: loader state, size codes,
// linear address and the mapper flags word
// ================================================
package nes_cart_pkg;

  typedef enum logic [1:0] {
    HEADER = 2'd0,  // Collecting the 16 header bytes
    PRG    = 2'd1,
    CHR    = 2'd2,
    FAIL   = 2'd3   // Bad header, held until reset
  } load_state_t;

  // Rounded-up log2 of a unit count, 0..7
  typedef logic [2:0] size_code_t;

  typedef logic [21:0] linear_addr_t;

  // ================================================
  // Mapper flags as decoded by the mapper logic
  // ================================================
  typedef struct packed {
    logic [7:0] pad;
    logic [3:0] hdr7_low;
    logic [3:0] hdr6_low;
    logic       has_chr_ram;  // No CHR ROM in the image
    logic       mirroring;
    size_code_t chr_size;
    size_code_t prg_size;
    logic [7:0] mapper;
  } mapper_fields_t;

  // Console core takes the raw word, mapper logic the fields
  typedef union packed {
    logic [31:0]    raw;
    mapper_fields_t fields;
  } mapper_flags_u;

endpackage

// File: verilog/nes_host_pkg.sv
// ================================================
// Host link types: register address, data byte
// and the controller button byte
// ================================================
package nes_host_pkg;

  // Register address from the serial host link
  typedef logic [7:0] host_addr_t;

  // Data byte written with each host strobe
  typedef logic [7:0] host_data_t;

  // Controller buttons in shift order
  // Bit 0 is A and goes out first
  // Then B, Select, Start, Up, Down, Left
  // Bit 7 is Right and goes out last
  typedef logic [7:0] buttons_t;

endpackage

// File: verilog/host_regs.sv
// ================================================
// Host register block: config, ROM stream, buttons
// ================================================
`include "nes_loader_macros.svh"

module host_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  nes_host_pkg::host_addr_t host_addr,
  input  nes_host_pkg::host_data_t host_data,
  input  logic                     host_write,
  output nes_host_pkg::host_data_t rom_byte,
  output logic                     rom_stb,
  output logic                     loader_reset,
  output nes_host_pkg::buttons_t   btn_1,
  output nes_host_pkg::buttons_t   btn_2
);

  nes_host_pkg::host_data_t conf_q;

  // ================================================
  // Control registers
  // ================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      conf_q  <= '0;
      btn_1   <= '0;
      btn_2   <= '0;
      rom_stb <= 1'b0;
    end else begin
      rom_stb <= host_write && (host_addr == `NES_REG_ROM);  // One cycle behind the write
      if (host_write) begin
        if (host_addr == `NES_REG_CONF) conf_q <= host_data;
        if (host_addr == `NES_REG_BTN1) btn_1 <= host_data;
        if (host_addr == `NES_REG_BTN2) btn_2 <= host_data;
      end
    end
  end

  // ROM byte travels with its strobe
  always_ff @(posedge clk) begin
    if (host_write && (host_addr == `NES_REG_ROM)) begin
      rom_byte <= host_data;
    end
  end

  // Soft reset from config bit 0 joins the system reset here only
  assign loader_reset = reset || conf_q[0];

endmodule

// File: verilog/ines_loader.sv
// ================================================
// iNES header parser and PRG/CHR address sequencer
// ================================================
`include "nes_loader_macros.svh"

module ines_loader (
  input  logic                        clk,
  input  logic                        loader_reset,
  input  nes_host_pkg::host_data_t    rom_byte,
  input  logic                        rom_stb,
  output nes_cart_pkg::linear_addr_t  load_addr,
  output nes_host_pkg::host_data_t    load_data,
  output logic                        load_write,
  output nes_cart_pkg::mapper_flags_u mapper_flags,
  output logic                        load_done,
  output logic                        load_error
);

  nes_cart_pkg::load_state_t  state;
  logic [3:0]                 hdr_cnt;     // Header byte index
  nes_host_pkg::host_data_t   hdr [8];     // Bytes 8..15 carry nothing used here
  nes_cart_pkg::linear_addr_t bytes_left;  // Left in current segment
  nes_cart_pkg::linear_addr_t prg_bytes;
  nes_cart_pkg::linear_addr_t chr_bytes;
  logic                       hdr_ok;
  logic                       in_segment;

  // Rounded-up log2 of a unit count, saturating at 7
  function automatic nes_cart_pkg::size_code_t size_code(input logic [7:0] units);
    nes_cart_pkg::size_code_t code;
    code = 3'd7;
    for (int i = 6; i >= 0; i--) begin
      if (units <= (9'd1 << i)) code = 3'(i);
    end
    return code;
  endfunction

  assign prg_bytes = nes_cart_pkg::linear_addr_t'(hdr[4]) << `NES_PRG_SHIFT;
  assign chr_bytes = nes_cart_pkg::linear_addr_t'(hdr[5]) << `NES_CHR_SHIFT;

  // Signature plus no trainer and no 4-screen layout
  assign hdr_ok = (hdr[0] == `NES_MAGIC_0) && (hdr[1] == `NES_MAGIC_1) &&
                  (hdr[2] == `NES_MAGIC_2) && (hdr[3] == `NES_MAGIC_3) &&
                  !hdr[6][2] && !hdr[6][3];

  assign in_segment = (state == nes_cart_pkg::PRG) || (state == nes_cart_pkg::CHR);
  assign load_write = in_segment && (bytes_left != '0) && rom_stb;
  assign load_data  = rom_byte;
  assign load_error = (state == nes_cart_pkg::FAIL);

  // Header storage
  always_ff @(posedge clk) begin
    if ((state == nes_cart_pkg::HEADER) && rom_stb && !hdr_cnt[3]) begin
      hdr[hdr_cnt[2:0]] <= rom_byte;
    end
  end

  // ================================================
  // Load sequencer
  // ================================================
  always_ff @(posedge clk) begin
    if (loader_reset) begin
      state      <= nes_cart_pkg::HEADER;
      hdr_cnt    <= '0;
      bytes_left <= '0;
      load_addr  <= '0;
      load_done  <= 1'b0;
    end else begin
      case (state)
        nes_cart_pkg::HEADER: begin
          if (rom_stb) begin
            hdr_cnt <= hdr_cnt + 4'd1;
            if (hdr_cnt == 4'hf) begin
              state      <= hdr_ok ? nes_cart_pkg::PRG : nes_cart_pkg::FAIL;
              bytes_left <= prg_bytes;
            end
          end
        end
        nes_cart_pkg::PRG, nes_cart_pkg::CHR: begin
          if (bytes_left != '0) begin
            if (rom_stb) begin
              bytes_left <= bytes_left - 22'd1;
              // Last PRG byte already points the address at CHR
              if ((state == nes_cart_pkg::PRG) && (bytes_left == 22'd1)) begin
                load_addr <= `NES_CHR_BASE;
              end else begin
                load_addr <= load_addr + 22'd1;
              end
            end
          end else if (state == nes_cart_pkg::PRG) begin
            state      <= nes_cart_pkg::CHR;  // Idle cycle between segments
            bytes_left <= chr_bytes;
            load_addr  <= `NES_CHR_BASE;
          end else begin
            load_done <= 1'b1;
          end
        end
        default: begin
          // FAIL holds until the next reset
        end
      endcase
    end
  end

  // Flags word from header bytes 4..7
  always_comb begin
    mapper_flags.fields.pad         = '0;
    mapper_flags.fields.hdr7_low    = hdr[7][3:0];
    mapper_flags.fields.hdr6_low    = hdr[6][3:0];
    mapper_flags.fields.has_chr_ram = (hdr[5] == '0);
    mapper_flags.fields.mirroring   = hdr[6][0];
    mapper_flags.fields.chr_size    = size_code(hdr[5]);
    mapper_flags.fields.prg_size    = size_code(hdr[4]);
    mapper_flags.fields.mapper      = {hdr[7][7:4], hdr[6][7:4]};
  end

endmodule

// File: verilog/joypad_port.sv
// ================================================
// Two controller shift registers
// ================================================
module joypad_port (
  input  logic                   clk,
  input  logic                   reset,
  input  nes_host_pkg::buttons_t btn_1,
  input  nes_host_pkg::buttons_t btn_2,
  input  nes_host_pkg::buttons_t usb_buttons,
  input  logic                   joypad_strobe,
  input  logic [1:0]             joypad_clock,
  output logic [1:0]             joypad_data
);

  nes_host_pkg::buttons_t shift_q [2];
  nes_host_pkg::buttons_t load_val [2];
  logic [1:0]             clock_q;  // Previous joypad_clock
  logic [1:0]             clock_fall;

  // Port 1 merges host and keypad buttons
  assign load_val[0] = btn_1 | usb_buttons;
  assign load_val[1] = btn_2;

  assign clock_fall = clock_q & ~joypad_clock;

  // ================================================
  // Shift registers
  // ================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q[0] <= '0;
      shift_q[1] <= '0;
      clock_q    <= '0;
    end else begin
      clock_q <= joypad_clock;
      for (int i = 0; i < 2; i++) begin
        if (joypad_strobe) begin
          shift_q[i] <= load_val[i];                 // Parallel load while strobed
        end else if (clock_fall[i]) begin
          shift_q[i] <= {1'b0, shift_q[i][7:1]};     // Zero fill after 8 bits
        end
      end
    end
  end

  assign joypad_data = {shift_q[1][0], shift_q[0][0]};

endmodule

// File: verilog/nes_loader_top.sv
// ================================================
// Loader front end: register block, iNES loader,
// joypad ports
// ================================================
module nes_loader_top (
  input  logic                        clk,
  input  logic                        reset,
  // Host link
  input  nes_host_pkg::host_data_t    host_data,
  input  nes_host_pkg::host_addr_t    host_addr,
  input  logic                        host_write,
  // Controller side
  input  logic                        joypad_strobe,
  input  logic [1:0]                  joypad_clock,
  input  nes_host_pkg::buttons_t      usb_buttons,
  output logic [1:0]                  joypad_data,
  // Memory load stream
  output nes_cart_pkg::linear_addr_t  load_addr,
  output nes_host_pkg::host_data_t    load_data,
  output logic                        load_write,
  output nes_cart_pkg::mapper_flags_u mapper_flags,
  output logic                        load_done,
  output logic                        load_error
);

  nes_host_pkg::host_data_t rom_byte;
  logic                     rom_stb;
  logic                     loader_reset;
  nes_host_pkg::buttons_t   btn_1;
  nes_host_pkg::buttons_t   btn_2;

  host_regs u_host_regs (
    .clk          (clk),
    .reset        (reset),
    .host_addr    (host_addr),
    .host_data    (host_data),
    .host_write   (host_write),
    .rom_byte     (rom_byte),
    .rom_stb      (rom_stb),
    .loader_reset (loader_reset),
    .btn_1        (btn_1),
    .btn_2        (btn_2)
  );

  ines_loader u_ines_loader (
    .clk          (clk),
    .loader_reset (loader_reset),
    .rom_byte     (rom_byte),
    .rom_stb      (rom_stb),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .load_write   (load_write),
    .mapper_flags (mapper_flags),
    .load_done    (load_done),
    .load_error   (load_error)
  );

  joypad_port u_joypad_port (
    .clk           (clk),
    .reset         (reset),
    .btn_1         (btn_1),
    .btn_2         (btn_2),
    .usb_buttons   (usb_buttons),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

endmodule

// File: verif/ines_loader_chk.sv
// ==================================================
// Loader output assertions, bound into ines_loader
// ==================================================
module ines_loader_chk (
  input logic                       clk,
  input logic                       loader_reset,
  input nes_cart_pkg::linear_addr_t load_addr,
  input logic                       load_write,
  input logic                       load_done,
  input logic                       load_error
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;  // Failed assertions so far

  // No memory writes once the load has ended either way
  write_while_ended: assert property (@(posedge clk) disable iff (loader_reset)
    !(load_write && (load_done || load_error)))
    else begin
      $error("load_write high after load_done or load_error");
      fail_count++;
    end

  done_and_error: assert property (@(posedge clk) disable iff (loader_reset)
    !(load_done && load_error))
    else begin
      $error("load_done and load_error high together");
      fail_count++;
    end

  // Address moves only after a write or a reset
  addr_moves_on_write: assert property (@(posedge clk) disable iff (loader_reset)
    $changed(load_addr) |-> ($past(load_write) || $past(loader_reset)))
    else begin
      $error("load_addr changed without a load_write");
      fail_count++;
    end

endmodule

bind ines_loader ines_loader_chk chk_i (
  .clk          (clk),
  .loader_reset (loader_reset),
  .load_addr    (load_addr),
  .load_write   (load_write),
  .load_done    (load_done),
  .load_error   (load_error)
);

// File: verif/nes_loader_tb.sv
// ==================================================
// Testbench for the loader front end: directed
// image loads, header rejects, soft reset, joypads
// ==================================================
`include "nes_loader_macros.svh"

module nes_loader_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // Bytes sent over all tests, header plus data plus trailing extras
  localparam int IMAGE_BYTES = (16 + 16384 + 8192) + (16 + 3 * 16384 + 4) +
                               2 * (16 + 8) + (16 + 16384);
  localparam int WATCHDOG_CYCLES = IMAGE_BYTES * 2 + 1000;

  logic                        clk;
  logic                        reset;
  nes_host_pkg::host_data_t    host_data;
  nes_host_pkg::host_addr_t    host_addr;
  logic                        host_write;
  logic                        joypad_strobe;
  logic [1:0]                  joypad_clock;
  nes_host_pkg::buttons_t      usb_buttons;
  logic [1:0]                  joypad_data;
  nes_cart_pkg::linear_addr_t  load_addr;
  nes_host_pkg::host_data_t    load_data;
  logic                        load_write;
  nes_cart_pkg::mapper_flags_u mapper_flags;
  logic                        load_done;
  logic                        load_error;

  nes_host_pkg::host_data_t   hdr_buf [16];  // Header of the image being sent
  nes_cart_pkg::linear_addr_t exp_addr_q [$];
  nes_host_pkg::host_data_t   exp_data_q [$];
  int prg_pulses;
  int chr_pulses;
  int value_errors = 0;
  int event_errors = 0;

  nes_loader_top dut_i (
    .clk           (clk),
    .reset         (reset),
    .host_data     (host_data),
    .host_addr     (host_addr),
    .host_write    (host_write),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .usb_buttons   (usb_buttons),
    .joypad_data   (joypad_data),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .load_write    (load_write),
    .mapper_flags  (mapper_flags),
    .load_done     (load_done),
    .load_error    (load_error)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout waiting for load_done");
    $display("Errors: %0d value, %0d other, %0d assertion", value_errors,
             event_errors + 1, dut_i.u_ines_loader.chk_i.fail_count);
    $display("Test failed");
    $finish;
  end

  // ==================================================
  // Compare and report
  // ==================================================
  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    value_errors++;
  endtask

  task automatic report_event(input string msg);
    $display("%0t: %s", $time, msg);
    event_errors++;
  endtask

  task automatic check_addr(input string name, input nes_cart_pkg::linear_addr_t got,
                            input nes_cart_pkg::linear_addr_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_byte(input string name, input nes_host_pkg::host_data_t got,
                            input nes_host_pkg::host_data_t exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) report_mismatch(name, got, exp);
  endtask

  task automatic check_flags(input nes_cart_pkg::mapper_flags_u got,
                             input nes_cart_pkg::mapper_flags_u exp);
    if (got.fields.mapper !== exp.fields.mapper)
      report_mismatch("mapper_flags.mapper", got.fields.mapper, exp.fields.mapper);
    if (got.fields.prg_size !== exp.fields.prg_size)
      report_mismatch("mapper_flags.prg_size", got.fields.prg_size, exp.fields.prg_size);
    if (got.fields.chr_size !== exp.fields.chr_size)
      report_mismatch("mapper_flags.chr_size", got.fields.chr_size, exp.fields.chr_size);
    if (got.fields.mirroring !== exp.fields.mirroring)
      report_mismatch("mapper_flags.mirroring", got.fields.mirroring, exp.fields.mirroring);
    if (got.fields.has_chr_ram !== exp.fields.has_chr_ram)
      report_mismatch("mapper_flags.has_chr_ram", got.fields.has_chr_ram,
                      exp.fields.has_chr_ram);
    if (got.fields.hdr6_low !== exp.fields.hdr6_low)
      report_mismatch("mapper_flags.hdr6_low", got.fields.hdr6_low, exp.fields.hdr6_low);
    if (got.fields.hdr7_low !== exp.fields.hdr7_low)
      report_mismatch("mapper_flags.hdr7_low", got.fields.hdr7_low, exp.fields.hdr7_low);
    if (got.fields.pad !== exp.fields.pad)
      report_mismatch("mapper_flags.pad", got.fields.pad, exp.fields.pad);
  endtask

  // ==================================================
  // Reference model
  // ==================================================
  function automatic nes_cart_pkg::size_code_t ceil_log2(input int units);
    int c;
    c = 0;
    while ((c < 7) && ((1 << c) < units)) c++;
    return nes_cart_pkg::size_code_t'(c);
  endfunction

  function automatic nes_cart_pkg::mapper_flags_u expected_flags();
    nes_cart_pkg::mapper_flags_u f;
    f.raw                = '0;
    f.fields.mapper      = {hdr_buf[7][7:4], hdr_buf[6][7:4]};
    f.fields.prg_size    = ceil_log2(hdr_buf[4]);
    f.fields.chr_size    = ceil_log2(hdr_buf[5]);
    f.fields.mirroring   = hdr_buf[6][0];
    f.fields.has_chr_ram = (hdr_buf[5] == 8'h00);
    f.fields.hdr6_low    = hdr_buf[6][3:0];
    f.fields.hdr7_low    = hdr_buf[7][3:0];
    return f;
  endfunction

  // Every write pulse must match the oldest expected byte
  always @(negedge clk) begin
    if (!reset && load_write) begin
      if (exp_addr_q.size() == 0) begin
        report_event($sformatf("load_write at 0x%0h where none was expected", load_addr));
      end else begin
        check_addr("load_addr", load_addr, exp_addr_q.pop_front());
        check_byte("load_data", load_data, exp_data_q.pop_front());
      end
      if (load_addr >= `NES_CHR_BASE) chr_pulses++;
      else prg_pulses++;
    end
  end

  // ==================================================
  // Drive helpers, called 5 ns after a rising edge
  // ==================================================
  task automatic write_reg(input nes_host_pkg::host_addr_t addr,
                           input nes_host_pkg::host_data_t data);
    host_addr  = addr;
    host_data  = data;
    host_write = 1'b1;
    @(posedge clk);
    #5 host_write = 1'b0;
  endtask

  task automatic soft_reset();
    write_reg(`NES_REG_CONF, 8'h01);
    write_reg(`NES_REG_CONF, 8'h00);
  endtask

  task automatic build_header(input logic [7:0] prg, input logic [7:0] chr,
                              input logic [7:0] f6, input logic [7:0] f7);
    hdr_buf = '{default: 8'h00};
    hdr_buf[0] = `NES_MAGIC_0;
    hdr_buf[1] = `NES_MAGIC_1;
    hdr_buf[2] = `NES_MAGIC_2;
    hdr_buf[3] = `NES_MAGIC_3;
    hdr_buf[4] = prg;
    hdr_buf[5] = chr;
    hdr_buf[6] = f6;
    hdr_buf[7] = f7;
  endtask

  // Header, then PRG and CHR when the header is good, then extra bytes
  task automatic send_image(input int extra);
    logic valid;
    int prg_len;
    int chr_len;
    nes_host_pkg::host_data_t b;
    prg_pulses = 0;
    chr_pulses = 0;
    valid = (hdr_buf[0] == `NES_MAGIC_0) && (hdr_buf[1] == `NES_MAGIC_1) &&
            (hdr_buf[2] == `NES_MAGIC_2) && (hdr_buf[3] == `NES_MAGIC_3) &&
            !hdr_buf[6][2] && !hdr_buf[6][3];
    prg_len = valid ? (int'(hdr_buf[4]) << `NES_PRG_SHIFT) : 0;
    chr_len = valid ? (int'(hdr_buf[5]) << `NES_CHR_SHIFT) : 0;
    for (int i = 0; i < 16; i++) write_reg(`NES_REG_ROM, hdr_buf[i]);
    for (int i = 0; i < prg_len; i++) begin
      b = nes_host_pkg::host_data_t'($urandom());
      exp_addr_q.push_back(nes_cart_pkg::linear_addr_t'(i));
      exp_data_q.push_back(b);
      write_reg(`NES_REG_ROM, b);
    end
    @(posedge clk);  // Segment switch needs an idle cycle
    #5;
    for (int i = 0; i < chr_len; i++) begin
      b = nes_host_pkg::host_data_t'($urandom());
      exp_addr_q.push_back(`NES_CHR_BASE + nes_cart_pkg::linear_addr_t'(i));
      exp_data_q.push_back(b);
      write_reg(`NES_REG_ROM, b);
    end
    for (int i = 0; i < extra; i++) write_reg(`NES_REG_ROM, 8'($urandom()));
  endtask

  // Flag is due within two cycles of the last write pulse
  task automatic wait_for_flag(input bit want_error);
    logic seen;
    seen = 1'b0;
    for (int i = 0; (i < 3) && !seen; i++) begin
      @(negedge clk);
      seen = want_error ? load_error : load_done;
    end
    if (!seen) report_event(want_error ? "load_error never rose" : "load_done never rose");
    if (exp_addr_q.size() != 0)
      report_event($sformatf("%0d expected load writes never came", exp_addr_q.size()));
    exp_addr_q.delete();
    exp_data_q.delete();
    @(posedge clk);
    #5;
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic load_valid_image();
    build_header(8'd1, 8'd1, 8'h21, 8'h10);  // Mapper 0x12, mirroring set
    send_image(0);
    wait_for_flag(1'b0);
    check_count("prg pulses", prg_pulses, 16384);
    check_count("chr pulses", chr_pulses, 8192);
    check_flags(mapper_flags, expected_flags());
    check_bit("load_error", load_error, 1'b0);
  endtask

  task automatic load_chr_ram_image();
    soft_reset();
    check_bit("load_done", load_done, 1'b0);  // Set by the previous image
    check_addr("load_addr", load_addr, '0);
    build_header(8'd3, 8'd0, 8'h00, 8'h00);
    send_image(4);  // Trailing bytes must be dropped
    wait_for_flag(1'b0);
    check_count("prg pulses", prg_pulses, 3 * 16384);
    check_count("chr pulses", chr_pulses, 0);
    check_flags(mapper_flags, expected_flags());
  endtask

  task automatic reject_bad_headers();
    soft_reset();
    build_header(8'd1, 8'd1, 8'h00, 8'h00);
    hdr_buf[1] = 8'h46;
    send_image(8);
    wait_for_flag(1'b1);
    check_bit("load_done", load_done, 1'b0);
    soft_reset();
    build_header(8'd1, 8'd1, 8'h04, 8'h00);  // Trainer bit
    send_image(8);
    wait_for_flag(1'b1);
  endtask

  task automatic restart_after_soft_reset();
    soft_reset();
    check_bit("load_error", load_error, 1'b0);
    build_header(8'd1, 8'd0, 8'h01, 8'h00);
    send_image(0);
    wait_for_flag(1'b0);
    check_count("prg pulses", prg_pulses, 16384);
  endtask

  task automatic read_joypads();
    nes_host_pkg::buttons_t port1;
    nes_host_pkg::buttons_t port2;
    port1 = 8'h85 | 8'h12;
    port2 = 8'h3c;
    write_reg(`NES_REG_BTN1, 8'h85);
    write_reg(`NES_REG_BTN2, 8'h3c);
    usb_buttons   = 8'h12;
    joypad_strobe = 1'b1;
    @(posedge clk);
    #5 joypad_strobe = 1'b0;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_bit("joypad_data[0]", joypad_data[0], (i < 8) ? port1[i] : 1'b0);
      check_bit("joypad_data[1]", joypad_data[1], (i < 8) ? port2[i] : 1'b0);
      @(posedge clk);
      #5 joypad_clock = 2'b11;
      @(posedge clk);
      #5 joypad_clock = 2'b00;
      @(posedge clk);  // Shift lands on this edge
      #5;
    end
  endtask

  initial begin
    reset         = 1'b1;
    host_data     = '0;
    host_addr     = '0;
    host_write    = 1'b0;
    joypad_strobe = 1'b0;
    joypad_clock  = 2'b00;
    usb_buttons   = '0;
    void'($urandom(23));
    repeat (16) @(posedge clk);
    #5 reset = 1'b0;
    check_bit("load_write", load_write, 1'b0);
    check_bit("load_done", load_done, 1'b0);
    check_bit("load_error", load_error, 1'b0);
    check_addr("load_addr", load_addr, '0);
    check_bit("joypad_data[0]", joypad_data[0], 1'b0);
    check_bit("joypad_data[1]", joypad_data[1], 1'b0);
    load_valid_image();
    load_chr_ram_image();
    reject_bad_headers();
    restart_after_soft_reset();
    read_joypads();
    $display("Errors: %0d value, %0d other, %0d assertion", value_errors, event_errors,
             dut_i.u_ines_loader.chk_i.fail_count);
    if ((value_errors + event_errors + dut_i.u_ines_loader.chk_i.fail_count) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: nes_loader_top.f
+incdir+verilog
verilog/nes_cart_pkg.sv
verilog/nes_host_pkg.sv
verilog/host_regs.sv
verilog/ines_loader.sv
verilog/joypad_port.sv
verilog/nes_loader_top.sv
verif/ines_loader_chk.sv
verif/nes_loader_tb.sv

// File: Bender.yml
package:
  name: nes_loader

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/nes_cart_pkg.sv
      - verilog/nes_host_pkg.sv
      - verilog/host_regs.sv
      - verilog/ines_loader.sv
      - verilog/joypad_port.sv
      - verilog/nes_loader_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/ines_loader_chk.sv
      - verif/nes_loader_tb.sv
